/* common/sd_cmd_pkg.sv */
package sd_cmd_pkg;

	typedef enum logic [1:0]
	{
		resp_none  = 2'd0,
		resp_short = 2'd1,
		resp_long  = 2'd2
	} resp_kind_e;

	typedef struct packed
	{
		logic [5:0]  index;
		logic [31:0] arg;
		resp_kind_e  kind;
	} cmd_req_t;

	// right-aligned, short responses sit in the low 48 bits
	typedef logic [135:0] resp_t;

	typedef struct packed
	{
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed
	{
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	localparam logic [2:0] REG_ARG    = 3'd0;
	localparam logic [2:0] REG_CMD    = 3'd1;
	localparam logic [2:0] REG_STATUS = 3'd2;
	localparam logic [2:0] REG_RESP0  = 3'd3; // words 3..7, lsw first

	localparam int CMD_FRAME_BITS = 48;
	localparam int LONG_RESP_BITS = 136;

	// x^7 + x^3 + 1, msb first
	function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
		logic fb;
		fb = din ^ crc[6];
		return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
	endfunction

endpackage

/* hw/cmd_wb_regs.sv */
`timescale 1ns/1ps

module cmd_wb_regs
(
	input  logic                 sd_clock,
	input  logic                 reset,
	input  sd_cmd_pkg::wb_req_t  wb_req,
	output sd_cmd_pkg::wb_rsp_t  wb_rsp,
	output logic                 cmd_strobe,
	output sd_cmd_pkg::cmd_req_t cmd_req,
	input  logic                 resp_strobe,
	input  sd_cmd_pkg::resp_t    resp,
	input  logic                 resp_timeout,
	input  logic                 resp_crc_error,
	output logic                 resp_ack
);

	logic              ack_q;
	logic [31:0]       rd_data;
	logic [31:0]       arg_reg;
	sd_cmd_pkg::resp_t resp_reg;
	logic              busy;
	logic              done;
	logic              timeout;
	logic              crc_error;
	logic              access;
	logic              cmd_write;
	logic [31:0]       rd_mux;

	assign access    = wb_req.cyc && wb_req.stb && !ack_q;
	assign cmd_write = access && wb_req.we && wb_req.adr == sd_cmd_pkg::REG_CMD && !busy;

	assign wb_rsp = '{ack: ack_q, dat: rd_data};

	always_comb
	begin
		case (wb_req.adr)
			sd_cmd_pkg::REG_ARG:    rd_mux = arg_reg;
			sd_cmd_pkg::REG_CMD:    rd_mux = {22'd0, cmd_req.kind, 2'd0, cmd_req.index};
			sd_cmd_pkg::REG_STATUS: rd_mux = {28'd0, crc_error, timeout, done, busy};
			3'd3:                   rd_mux = resp_reg[31:0];
			3'd4:                   rd_mux = resp_reg[63:32];
			3'd5:                   rd_mux = resp_reg[95:64];
			3'd6:                   rd_mux = resp_reg[127:96];
			default:                rd_mux = {24'd0, resp_reg[135:128]};
		endcase
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			ack_q      <= 1'b0;
			cmd_strobe <= 1'b0;
			resp_ack   <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			timeout    <= 1'b0;
			crc_error  <= 1'b0;
		end
		else
		begin
			ack_q      <= access;
			cmd_strobe <= cmd_write;
			resp_ack   <= resp_strobe;
			if (cmd_write)
			begin
				busy      <= 1'b1;
				done      <= 1'b0;
				timeout   <= 1'b0;
				crc_error <= 1'b0;
			end
			if (resp_strobe)
			begin
				timeout   <= resp_timeout;
				crc_error <= resp_crc_error;
			end
			if (resp_ack) // transaction closes here
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (access)
			rd_data <= rd_mux;
		if (access && wb_req.we && wb_req.adr == sd_cmd_pkg::REG_ARG)
			arg_reg <= wb_req.dat;
		if (cmd_write)
		begin
			cmd_req.index <= wb_req.dat[5:0];
			cmd_req.kind  <= sd_cmd_pkg::resp_kind_e'(wb_req.dat[9:8]);
			cmd_req.arg   <= arg_reg;
		end
		// last response stays when the card sent nothing
		if (resp_strobe && !resp_timeout && cmd_req.kind != sd_cmd_pkg::resp_none)
			resp_reg <= resp;
	end

	resp_while_busy: assert property (@(posedge sd_clock) disable iff (reset)
		resp_strobe |-> busy);

endmodule

/* cmd_phys/cmd_phys_controller.sv */
`timescale 1ns/1ps

module cmd_phys_controller
#(
	parameter int RESP_TIMEOUT = 64
)
(
	input  logic                 sd_clock,
	input  logic                 reset,
	input  logic                 cmd_strobe,
	input  sd_cmd_pkg::cmd_req_t cmd_req,
	input  logic                 resp_ack,
	output logic                 tx_enable,
	output sd_cmd_pkg::cmd_req_t tx_req,
	input  logic                 tx_done,
	output logic                 rx_enable,
	output logic                 rx_long,
	input  logic                 rx_done,
	input  logic                 rx_active,
	input  sd_cmd_pkg::resp_t    rx_data,
	input  logic                 rx_crc_error,
	output logic                 resp_strobe,
	output sd_cmd_pkg::resp_t    resp,
	output logic                 resp_timeout,
	output logic                 resp_crc_error
);

	localparam int TO_W = (RESP_TIMEOUT > 2) ? $clog2(RESP_TIMEOUT) : 1;
	localparam logic [TO_W-1:0] TO_LAST = TO_W'(RESP_TIMEOUT - 1);

	typedef enum logic [2:0]
	{
		st_idle,
		st_load,
		st_send,
		st_wait_resp,
		st_send_resp,
		st_wait_ack
	} state_e;

	state_e          state;
	state_e          next_state;
	logic [TO_W-1:0] timeout_count;
	logic            timed_out;

	assign timed_out = timeout_count == TO_LAST && !rx_active;

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (cmd_strobe)
					next_state = st_load;
			st_load:
				next_state = st_send;
			st_send:
				if (tx_done)
				begin
					if (tx_req.kind == sd_cmd_pkg::resp_none)
						next_state = st_send_resp; // nothing to wait for
					else
						next_state = st_wait_resp;
				end
			st_wait_resp:
				if (rx_done || timed_out)
					next_state = st_send_resp;
			st_send_resp:
				next_state = st_wait_ack;
			st_wait_ack:
				if (resp_ack)
					next_state = st_idle;
			default:
				next_state = st_idle;
		endcase
	end

	assign tx_enable   = state == st_send;
	assign rx_enable   = state == st_wait_resp;
	assign rx_long     = rx_enable && tx_req.kind == sd_cmd_pkg::resp_long;
	assign resp_strobe = state == st_send_resp;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state          <= st_idle;
			timeout_count  <= '0;
			resp_timeout   <= 1'b0;
			resp_crc_error <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == st_wait_resp && !rx_active)
				timeout_count <= timeout_count + 1'b1;
			else if (state != st_wait_resp)
				timeout_count <= '0;
			if (state == st_load)
			begin
				resp_timeout   <= 1'b0;
				resp_crc_error <= 1'b0;
			end
			if (state == st_wait_resp)
			begin
				if (rx_done)
					resp_crc_error <= rx_crc_error;
				else if (timed_out)
					resp_timeout <= 1'b1;
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (state == st_load)
			tx_req <= cmd_req;
		if (state == st_wait_resp && rx_done)
			resp <= rx_data;
	end

	tx_done_in_send: assert property (@(posedge sd_clock) disable iff (reset)
		tx_done |-> tx_enable);

endmodule

/* cmd_phys/cmd_serializer.sv */
`timescale 1ns/1ps

module cmd_serializer
(
	input  logic                 sd_clock,
	input  logic                 reset,
	input  logic                 tx_enable,
	input  sd_cmd_pkg::cmd_req_t tx_req,
	output logic                 cmd_out,
	output logic                 cmd_oe,
	output logic                 tx_done
);

	localparam logic [5:0] LAST_BIT = 6'(sd_cmd_pkg::CMD_FRAME_BITS - 1);

	logic [39:0] shift_reg;
	logic [6:0]  crc;
	logic [5:0]  bit_cnt;

	// start, prefix, crc, end bit
	always_comb
	begin
		if (!cmd_oe)
			cmd_out = 1'b1;
		else if (bit_cnt < 6'd40)
			cmd_out = shift_reg[39];
		else if (bit_cnt < LAST_BIT)
			cmd_out = crc[6];
		else
			cmd_out = 1'b1;
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			cmd_oe  <= 1'b0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (!cmd_oe && tx_enable && !tx_done)
				cmd_oe <= 1'b1;
			else if (cmd_oe && bit_cnt == LAST_BIT)
			begin
				cmd_oe  <= 1'b0;
				tx_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (!cmd_oe)
		begin
			shift_reg <= {1'b0, 1'b1, tx_req.index, tx_req.arg};
			crc       <= '0;
			bit_cnt   <= '0;
		end
		else
		begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt < 6'd40)
			begin
				crc       <= sd_cmd_pkg::crc7_next(crc, shift_reg[39]);
				shift_reg <= {shift_reg[38:0], 1'b0};
			end
			else
				crc <= {crc[5:0], 1'b0};
		end
	end

endmodule

/* cmd_phys/cmd_deserializer.sv */
`timescale 1ns/1ps

module cmd_deserializer
(
	input  logic              sd_clock,
	input  logic              reset,
	input  logic              rx_enable,
	input  logic              rx_long,
	input  logic              cmd_in,
	output logic              rx_active,
	output logic              rx_done,
	output sd_cmd_pkg::resp_t rx_data,
	output logic              rx_crc_error
);

	localparam logic [7:0] SHORT_LAST = 8'(sd_cmd_pkg::CMD_FRAME_BITS - 1);
	localparam logic [7:0] LONG_LAST  = 8'(sd_cmd_pkg::LONG_RESP_BITS - 1);

	sd_cmd_pkg::resp_t shift_reg;
	logic [6:0]        crc;
	logic [7:0]        bit_cnt;
	logic [7:0]        last_bit;
	logic              start;

	assign last_bit = rx_long ? LONG_LAST : SHORT_LAST;
	assign start    = rx_enable && !rx_active && !rx_done && !cmd_in;
	assign rx_data  = shift_reg;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			rx_active    <= 1'b0;
			rx_done      <= 1'b0;
			rx_crc_error <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			if (start)
			begin
				rx_active    <= 1'b1;
				rx_crc_error <= 1'b0;
			end
			else if (rx_active && bit_cnt == last_bit)
			begin
				rx_active <= 1'b0;
				rx_done   <= 1'b1;
				// crc field is frame bits 7:1, still in 6:0 before this shift
				rx_crc_error <= !rx_long && shift_reg[6:0] != crc;
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (start)
		begin
			shift_reg <= {135'd0, cmd_in};
			crc       <= sd_cmd_pkg::crc7_next(7'd0, cmd_in);
			bit_cnt   <= 8'd1;
		end
		else if (rx_active)
		begin
			shift_reg <= {shift_reg[134:0], cmd_in};
			bit_cnt   <= bit_cnt + 1'b1;
			if (bit_cnt < 8'd40)
				crc <= sd_cmd_pkg::crc7_next(crc, cmd_in);
		end
	end

endmodule

/* hw/sd_cmd_host.sv */
`timescale 1ns/1ps

module sd_cmd_host
#(
	parameter int RESP_TIMEOUT = 64
)
(
	input  logic                sd_clock,
	input  logic                reset,
	input  sd_cmd_pkg::wb_req_t wb_req,
	output sd_cmd_pkg::wb_rsp_t wb_rsp,
	input  logic                cmd_in,
	output logic                cmd_out,
	output logic                cmd_oe
);

	logic                 cmd_strobe;
	sd_cmd_pkg::cmd_req_t cmd_req;
	logic                 resp_ack;
	logic                 resp_strobe;
	sd_cmd_pkg::resp_t    resp;
	logic                 resp_timeout;
	logic                 resp_crc_error;
	logic                 tx_enable;
	sd_cmd_pkg::cmd_req_t tx_req;
	logic                 tx_done;
	logic                 rx_enable;
	logic                 rx_long;
	logic                 rx_done;
	logic                 rx_active;
	sd_cmd_pkg::resp_t    rx_data;
	logic                 rx_crc_error;

	cmd_wb_regs u_cmd_wb_regs
	(
		.sd_clock       (sd_clock),
		.reset          (reset),
		.wb_req         (wb_req),
		.wb_rsp         (wb_rsp),
		.cmd_strobe     (cmd_strobe),
		.cmd_req        (cmd_req),
		.resp_strobe    (resp_strobe),
		.resp           (resp),
		.resp_timeout   (resp_timeout),
		.resp_crc_error (resp_crc_error),
		.resp_ack       (resp_ack)
	);

	cmd_phys_controller #(.RESP_TIMEOUT(RESP_TIMEOUT)) u_cmd_phys_controller
	(
		.sd_clock       (sd_clock),
		.reset          (reset),
		.cmd_strobe     (cmd_strobe),
		.cmd_req        (cmd_req),
		.resp_ack       (resp_ack),
		.tx_enable      (tx_enable),
		.tx_req         (tx_req),
		.tx_done        (tx_done),
		.rx_enable      (rx_enable),
		.rx_long        (rx_long),
		.rx_done        (rx_done),
		.rx_active      (rx_active),
		.rx_data        (rx_data),
		.rx_crc_error   (rx_crc_error),
		.resp_strobe    (resp_strobe),
		.resp           (resp),
		.resp_timeout   (resp_timeout),
		.resp_crc_error (resp_crc_error)
	);

	cmd_serializer u_cmd_serializer
	(
		.sd_clock  (sd_clock),
		.reset     (reset),
		.tx_enable (tx_enable),
		.tx_req    (tx_req),
		.cmd_out   (cmd_out),
		.cmd_oe    (cmd_oe),
		.tx_done   (tx_done)
	);

	cmd_deserializer u_cmd_deserializer
	(
		.sd_clock     (sd_clock),
		.reset        (reset),
		.rx_enable    (rx_enable),
		.rx_long      (rx_long),
		.cmd_in       (cmd_in),
		.rx_active    (rx_active),
		.rx_done      (rx_done),
		.rx_data      (rx_data),
		.rx_crc_error (rx_crc_error)
	);

endmodule

/* bench/sd_card_cmd_model.sv */
`timescale 1ns/1ps

module sd_card_cmd_model
(
	input  logic        sd_clock,
	input  logic        cmd_out,
	input  logic        cmd_oe,
	input  logic [1:0]  resp_kind,
	output logic        cmd_in,
	output logic [5:0]  rx_index,
	output logic [31:0] rx_arg,
	output logic        rx_crc_ok,
	output logic [7:0]  oe_cycles,
	output logic [7:0]  cmd_count
);

	logic [47:0]  frame;
	logic [135:0] answer;
	int           answer_bits;
	int           delay;
	integer       seed;
	int           i;

	// remainder of msg * x^7 over x^7 + x^3 + 1
	function automatic logic [6:0] crc7_of(input logic [39:0] msg);
		logic [46:0] rem;
		int          k;
		rem = {msg, 7'd0};
		for (k = 46; k >= 7; k--)
			if (rem[k])
				rem[k -: 8] = rem[k -: 8] ^ 8'h89;
		return rem[6:0];
	endfunction

	initial
	begin
		seed      = 58320;
		cmd_in    = 1'b1;
		cmd_count = '0;
		oe_cycles = '0;
		rx_index  = '0;
		rx_arg    = '0;
		rx_crc_ok = 1'b0;
		forever
		begin
			@(negedge sd_clock);
			if (cmd_oe)
			begin
				frame     = '0;
				oe_cycles = '0;
				while (cmd_oe)
				begin
					frame     = {frame[46:0], cmd_out};
					oe_cycles = oe_cycles + 1'b1;
					@(negedge sd_clock);
				end
				rx_index  = frame[45:40];
				rx_arg    = frame[39:8];
				rx_crc_ok = frame[47:46] == 2'b01 && frame[0] && frame[7:1] == crc7_of(frame[47:8]);
				cmd_count = cmd_count + 1'b1;
				answer_bits = 0;
				if (rx_index != 6'd63 && resp_kind == 2'd1)
				begin
					answer = {88'd0, 2'b00, rx_index, ~rx_arg,
						crc7_of({2'b00, rx_index, ~rx_arg}), 1'b1};
					if (rx_index == 6'd62)
						answer[1] = ~answer[1]; // corrupt crc lsb
					answer_bits = 48;
				end
				else if (rx_index != 6'd63 && resp_kind == 2'd2)
				begin
					answer    = {8'h3F, rx_arg, ~rx_arg, rx_arg, ~rx_arg};
					answer[0] = 1'b1; // end bit in place of payload lsb, 136 bits total
					answer_bits = 136;
				end
				if (answer_bits > 0)
				begin
					delay = 2 + ($unsigned($random(seed)) % 19);
					repeat (delay) @(negedge sd_clock);
					for (i = answer_bits - 1; i >= 0; i--)
					begin
						cmd_in = answer[i];
						@(negedge sd_clock);
					end
					cmd_in = 1'b1;
				end
			end
		end
	end

endmodule

/* bench/sd_cmd_host_tb.sv */
`timescale 1ns/1ps

module sd_cmd_host_tb;

	localparam int NUM_ROWS    = 6;
	localparam int CYCLE_LIMIT = 400 * NUM_ROWS + 100;
	localparam int POLL_LIMIT  = 200;

	typedef struct packed
	{
		logic [5:0]  index;
		logic [31:0] arg;
		logic [1:0]  kind;
		logic        exp_timeout;
		logic        exp_crc;
	} row_t;

	logic                sd_clock;
	logic                reset;
	sd_cmd_pkg::wb_req_t wb_req;
	sd_cmd_pkg::wb_rsp_t wb_rsp;
	logic                cmd_in;
	logic                cmd_out;
	logic                cmd_oe;
	logic [1:0]          card_kind;
	logic [5:0]          card_index;
	logic [31:0]         card_arg;
	logic                card_crc_ok;
	logic [7:0]          card_oe_cycles;
	logic [7:0]          card_cmd_count;
	row_t                table_rows [NUM_ROWS];
	logic [135:0]        last_resp;
	int                  errors;
	int                  checks;
	int                  cycles;
	logic [31:0]         word;
	int                  r;

	sd_cmd_host #(.RESP_TIMEOUT(64)) u_sd_cmd_host
	(
		.sd_clock (sd_clock),
		.reset    (reset),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.cmd_in   (cmd_in),
		.cmd_out  (cmd_out),
		.cmd_oe   (cmd_oe)
	);

	sd_card_cmd_model u_card
	(
		.sd_clock  (sd_clock),
		.cmd_out   (cmd_out),
		.cmd_oe    (cmd_oe),
		.resp_kind (card_kind),
		.cmd_in    (cmd_in),
		.rx_index  (card_index),
		.rx_arg    (card_arg),
		.rx_crc_ok (card_crc_ok),
		.oe_cycles (card_oe_cycles),
		.cmd_count (card_cmd_count)
	);

	initial
	begin
		sd_clock = 1'b0;
		forever #5 sd_clock = ~sd_clock;
	end

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge sd_clock);
			cycles++;
		end
		$display("run stopped after %0d cycles without finishing", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [6:0] crc7_of(input logic [39:0] msg);
		logic [46:0] rem;
		int          k;
		rem = {msg, 7'd0};
		for (k = 46; k >= 7; k--)
			if (rem[k])
				rem[k -: 8] = rem[k -: 8] ^ 8'h89;
		return rem[6:0];
	endfunction

	function automatic logic [135:0] build_response(input logic [5:0] index,
		input logic [31:0] arg, input logic [1:0] kind);
		logic [135:0] frame;
		if (kind == 2'd2)
		begin
			frame    = {8'h3F, arg, ~arg, arg, ~arg};
			frame[0] = 1'b1;
		end
		else
		begin
			frame = {88'd0, 2'b00, index, ~arg, crc7_of({2'b00, index, ~arg}), 1'b1};
			if (index == 6'd62)
				frame[1] = ~frame[1];
		end
		return frame;
	endfunction

	task automatic check_equal(input string name, input logic [135:0] got,
		input logic [135:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [31:0] dat);
		@(negedge sd_clock);
		wb_req = {1'b1, 1'b1, 1'b1, adr, dat};
		@(negedge sd_clock);
		while (!wb_rsp.ack)
			@(negedge sd_clock);
		wb_req = '0;
	endtask

	task automatic read_reg(input logic [2:0] adr, output logic [31:0] dat);
		@(negedge sd_clock);
		wb_req = {1'b1, 1'b1, 1'b0, adr, 32'd0};
		@(negedge sd_clock);
		while (!wb_rsp.ack)
			@(negedge sd_clock);
		dat    = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic apply_row(input int idx);
		row_t         row;
		logic [31:0]  status;
		logic [31:0]  data;
		logic [159:0] got_words;
		logic [135:0] exp_resp;
		logic [7:0]   count_before;
		int           errors_before;
		int           polls;
		int           w;
		row           = table_rows[idx];
		errors_before = errors;
		count_before  = card_cmd_count;
		card_kind     = row.kind;
		write_reg(sd_cmd_pkg::REG_ARG, row.arg);
		write_reg(sd_cmd_pkg::REG_CMD, {22'd0, row.kind, 2'd0, row.index});
		write_reg(sd_cmd_pkg::REG_CMD, {22'd0, 2'd2, 2'd0, row.index ^ 6'h01}); // lands while busy
		status = '0;
		polls  = 0;
		while (!status[1] && polls < POLL_LIMIT)
		begin
			read_reg(sd_cmd_pkg::REG_STATUS, status);
			polls++;
		end
		checks++;
		assert (status[1])
		else
		begin
			$display("row %0d: status never showed done", idx);
			errors++;
		end
		check_equal("status", status, {28'd0, row.exp_crc, row.exp_timeout, 2'b10});
		check_equal("card cmd_count", card_cmd_count, count_before + 8'd1);
		check_equal("cmd_oe cycles", card_oe_cycles, 8'd48);
		check_equal("card index", card_index, row.index);
		check_equal("card arg", card_arg, row.arg);
		check_equal("command crc ok", card_crc_ok, 1'b1);
		read_reg(sd_cmd_pkg::REG_CMD, data);
		check_equal("cmd register", data, {22'd0, row.kind, 2'd0, row.index});
		if (row.kind == 2'd0 || row.exp_timeout)
			exp_resp = last_resp; // nothing new from the card
		else
			exp_resp = build_response(row.index, row.arg, row.kind);
		for (w = 0; w < 5; w++)
		begin
			read_reg(3'(sd_cmd_pkg::REG_RESP0 + w), data);
			got_words[w * 32 +: 32] = data;
		end
		check_equal("response", got_words[135:0], exp_resp);
		check_equal("resp word 4 upper", got_words[159:136], 24'd0);
		last_resp = exp_resp;
		$display("row %0d index %0d kind %0d done, %0d errors", idx, row.index, row.kind,
			errors - errors_before);
	endtask

	initial
	begin
		reset     = 1'b1;
		wb_req    = '0;
		card_kind = 2'd0;
		errors    = 0;
		checks    = 0;
		last_resp = '0;
		table_rows[0] = {6'd8,  32'h000001AA, 2'd1, 1'b0, 1'b0};
		table_rows[1] = {6'd2,  32'h12345678, 2'd2, 1'b0, 1'b0};
		table_rows[2] = {6'd0,  32'h00000000, 2'd0, 1'b0, 1'b0};
		table_rows[3] = {6'd63, 32'hDEADBEEF, 2'd1, 1'b1, 1'b0}; // never answered
		table_rows[4] = {6'd62, 32'h0F0F00F0, 2'd1, 1'b0, 1'b1}; // bad crc
		table_rows[5] = {6'd17, 32'hCAFE0001, 2'd1, 1'b0, 1'b0};
		repeat (4) @(negedge sd_clock);
		reset = 1'b0;
		read_reg(sd_cmd_pkg::REG_STATUS, word);
		check_equal("status after reset", word, 32'd0);
		check_equal("cmd_oe after reset", cmd_oe, 1'b0);
		check_equal("cmd_out after reset", cmd_out, 1'b1);
		$display("reset test done, %0d errors", errors);
		for (r = 0; r < NUM_ROWS; r++)
			apply_row(r);
		$display("%0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* sd_cmd_host.f */
common/sd_cmd_pkg.sv
hw/cmd_wb_regs.sv
cmd_phys/cmd_phys_controller.sv
cmd_phys/cmd_serializer.sv
cmd_phys/cmd_deserializer.sv
hw/sd_cmd_host.sv
bench/sd_card_cmd_model.sv
bench/sd_cmd_host_tb.sv

/* Bender.yml */
package:
  name: sd_cmd_host

sources:
  - common/sd_cmd_pkg.sv
  - hw/cmd_wb_regs.sv
  - cmd_phys/cmd_phys_controller.sv
  - cmd_phys/cmd_serializer.sv
  - cmd_phys/cmd_deserializer.sv
  - hw/sd_cmd_host.sv
  - target: simulation
    files:
      - bench/sd_card_cmd_model.sv
      - bench/sd_cmd_host_tb.sv
